//--- flist.f
+incdir+include
verilog/core_pkg.sv
verilog/instr_decode.sv
verilog/dispatch_ctrl.sv
verilog/rename_table.sv
verilog/rob.sv
verilog/add_sub_rs.sv
verilog/add_sub_unit.sv
verilog/tomasulo_core.sv
dv/tb_checker.sv
dv/tb_top.sv

//--- Bender.yml
package:
  name: tomasulo_core

sources:
  - verilog/core_pkg.sv
  - verilog/instr_decode.sv
  - verilog/dispatch_ctrl.sv
  - verilog/rename_table.sv
  - verilog/rob.sv
  - verilog/add_sub_rs.sv
  - verilog/add_sub_unit.sv
  - verilog/tomasulo_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/tb_checker.sv
      - dv/tb_top.sv

//--- include/tb_tests.svh
// opcode kinds used by the stimulus table
localparam logic [2:0] K_ADD  = 3'd0;
localparam logic [2:0] K_SUB  = 3'd1;
localparam logic [2:0] K_LOAD = 3'd2;
localparam logic [2:0] K_MUL  = 3'd3;
localparam logic [2:0] K_DIV  = 3'd4;

// what stall is expected to do during a test
localparam int STALL_ANY   = 0;
localparam int STALL_SEEN  = 1;
localparam int STALL_NEVER = 2;

typedef struct packed {
    logic [2:0]  kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic        commits;
    logic [31:0] value;
} row_t;

localparam int NUM_TESTS = 6;
localparam int NUM_ROWS  = 35;

localparam string TEST_NAME [NUM_TESTS] = '{
    "idle_after_reset", "independent", "dep_chain",
    "reg_reuse_x0", "burst16", "dropped_ops"
};
localparam int TEST_ROWS [NUM_TESTS] = '{0, 4, 4, 6, 16, 5};
localparam int TEST_STALL [NUM_TESTS] = '{
    STALL_NEVER, STALL_ANY, STALL_ANY, STALL_ANY, STALL_SEEN, STALL_ANY
};

// columns: kind, rd, rs1, rs2, commits, expected rd value
// values follow program order from the reset register table
localparam row_t ROWS [NUM_ROWS] = '{
    // independent, x13 wraps below zero
    '{K_ADD, 5'd11, 5'd1, 5'd2, 1'b1, 32'h0000_001c},
    '{K_SUB, 5'd12, 5'd3, 5'd4, 1'b1, 32'h0000_0028},
    '{K_SUB, 5'd13, 5'd5, 5'd6, 1'b1, 32'hffff_ffff},
    '{K_ADD, 5'd14, 5'd7, 5'd8, 1'b1, 32'h0000_0003},
    // dependent chain
    '{K_ADD, 5'd1, 5'd2, 5'd2, 1'b1, 32'h0000_0020},
    '{K_ADD, 5'd2, 5'd2, 5'd1, 1'b1, 32'h0000_0030},
    '{K_ADD, 5'd6, 5'd2, 5'd5, 1'b1, 32'h0000_0033},
    '{K_ADD, 5'd5, 5'd2, 5'd6, 1'b1, 32'h0000_0063},
    // x15 rewritten three times, then x0 written and read
    '{K_ADD, 5'd15, 5'd7, 5'd8, 1'b1, 32'h0000_0003},
    '{K_ADD, 5'd15, 5'd15, 5'd9, 1'b1, 32'h0000_0005},
    '{K_SUB, 5'd15, 5'd15, 5'd10, 1'b1, 32'h0000_0002},
    '{K_ADD, 5'd16, 5'd15, 5'd15, 1'b1, 32'h0000_0004},
    '{K_ADD, 5'd0, 5'd3, 5'd4, 1'b1, 32'h0000_0032},
    '{K_ADD, 5'd17, 5'd0, 5'd7, 1'b1, 32'h0000_0001},
    // burst on x18, +3 then -1
    '{K_ADD, 5'd18, 5'd18, 5'd10, 1'b1, 32'h0000_0003},
    '{K_SUB, 5'd18, 5'd18, 5'd7, 1'b1, 32'h0000_0002},
    '{K_ADD, 5'd18, 5'd18, 5'd10, 1'b1, 32'h0000_0005},
    '{K_SUB, 5'd18, 5'd18, 5'd7, 1'b1, 32'h0000_0004},
    '{K_ADD, 5'd18, 5'd18, 5'd10, 1'b1, 32'h0000_0007},
    '{K_SUB, 5'd18, 5'd18, 5'd7, 1'b1, 32'h0000_0006},
    '{K_ADD, 5'd18, 5'd18, 5'd10, 1'b1, 32'h0000_0009},
    '{K_SUB, 5'd18, 5'd18, 5'd7, 1'b1, 32'h0000_0008},
    '{K_ADD, 5'd18, 5'd18, 5'd10, 1'b1, 32'h0000_000b},
    '{K_SUB, 5'd18, 5'd18, 5'd7, 1'b1, 32'h0000_000a},
    '{K_ADD, 5'd18, 5'd18, 5'd10, 1'b1, 32'h0000_000d},
    '{K_SUB, 5'd18, 5'd18, 5'd7, 1'b1, 32'h0000_000c},
    '{K_ADD, 5'd18, 5'd18, 5'd10, 1'b1, 32'h0000_000f},
    '{K_SUB, 5'd18, 5'd18, 5'd7, 1'b1, 32'h0000_000e},
    '{K_ADD, 5'd18, 5'd18, 5'd10, 1'b1, 32'h0000_0011},
    '{K_SUB, 5'd18, 5'd18, 5'd7, 1'b1, 32'h0000_0010},
    // dropped words aim at x1, x2, x5 and must not touch them
    '{K_LOAD, 5'd1, 5'd3, 5'd0, 1'b0, 32'h0000_0000},
    '{K_MUL, 5'd2, 5'd3, 5'd4, 1'b0, 32'h0000_0000},
    '{K_DIV, 5'd5, 5'd3, 5'd4, 1'b0, 32'h0000_0000},
    '{K_ADD, 5'd22, 5'd1, 5'd2, 1'b1, 32'h0000_0050},
    '{K_ADD, 5'd23, 5'd5, 5'd6, 1'b1, 32'h0000_0096}
};

// rows of one test that should reach the commit port
function automatic int count_expected_commits(input int first, input int count);
    int n;
    n = 0;
    for (int r = first; r < first + count; r++) begin
        if (ROWS[r].commits) begin
            n++;
        end
    end
    return n;
endfunction

//--- dv/tb_top.sv
`timescale 1ns/100ps

module tb_top import core_pkg::*; ();

    `include "tb_tests.svh"

    localparam int RESET_CYCLES  = 5;
    // quiet window after the last commit, catches extras
    localparam int SETTLE_CYCLES = 8;
    // budget per table row
    localparam int ROW_CYCLES    = 20;
    localparam int MAX_CYCLES    = ROW_CYCLES * NUM_ROWS + RESET_CYCLES;

    logic        clk;
    logic        reset;
    logic [31:0] instr;
    logic        instr_valid;
    logic        stall;
    commit_t     commit;
    logic        test_end;
    int          seen;
    int          passed;
    int          failed;
    int          cycle_count;

    tomasulo_core #(.RS_DEPTH(4)) u_dut (
        .clk         (clk),
        .reset       (reset),
        .instr       (instr),
        .instr_valid (instr_valid),
        .stall       (stall),
        .commit      (commit)
    );

    tb_checker u_checker (
        .clk      (clk),
        .reset    (reset),
        .stall    (stall),
        .commit   (commit),
        .test_end (test_end),
        .seen     (seen),
        .passed   (passed),
        .failed   (failed)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // rv32 encodings straight from the isa tables
    function automatic logic [31:0] encode(input row_t r);
        case (r.kind)
            K_ADD:   return {7'b0000000, r.rs2, r.rs1, 3'b000, r.rd, 7'b0110011};
            K_SUB:   return {7'b0100000, r.rs2, r.rs1, 3'b000, r.rd, 7'b0110011};
            K_MUL:   return {7'b0000001, r.rs2, r.rs1, 3'b000, r.rd, 7'b0110011};
            K_DIV:   return {7'b0000001, r.rs2, r.rs1, 3'b100, r.rd, 7'b0110011};
            // lw rd, 16(rs1)
            default: return {12'h010, r.rs1, 3'b010, r.rd, 7'b0000011};
        endcase
    endfunction

    // hold the word until an edge with stall low takes it
    task automatic send_word(input logic [31:0] word);
        instr       <= word;
        instr_valid <= 1'b1;
        @(posedge clk);
        while (stall) begin
            @(posedge clk);
        end
    endtask

    // ====================
    // test loop
    // ====================

    initial begin
        int first;
        int n_commit;
        int wait_cycles;
        reset       = 1'b1;
        instr       = '0;
        instr_valid = 1'b0;
        test_end    = 1'b0;
        first       = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            for (int r = first; r < first + TEST_ROWS[t]; r++) begin
                send_word(encode(ROWS[r]));
            end
            instr_valid <= 1'b0;
            n_commit = count_expected_commits(first, TEST_ROWS[t]);
            wait_cycles = 0;
            // idle until every commit is seen or the test runs out of cycles
            while (seen < n_commit && wait_cycles < ROW_CYCLES * TEST_ROWS[t]) begin
                @(posedge clk);
                wait_cycles++;
            end
            repeat (SETTLE_CYCLES) @(posedge clk);
            test_end <= 1'b1;
            @(posedge clk);
            test_end <= 1'b0;
            first += TEST_ROWS[t];
        end
        // one more edge for the checker counts to settle
        @(posedge clk);
        $display("%0d tests passed, %0d tests failed", passed, failed);
        if (failed == 0 && passed == NUM_TESTS) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // ====================
    // timeout
    // ====================

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the tests did not finish", cycle_count);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- dv/tb_checker.sv
`timescale 1ns/100ps

module tb_checker import core_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    stall,
    input  commit_t commit,
    input  logic    test_end,
    output int      seen,
    output int      passed,
    output int      failed
);

    `include "tb_tests.svh"

    int cur_test;
    int first_row;
    int last_row;
    int row_ptr;
    int errors;
    int seen_cnt;
    int pass_cnt;
    int fail_cnt;
    bit stall_seen;

    initial begin
        cur_test   = 0;
        first_row  = 0;
        last_row   = TEST_ROWS[0];
        row_ptr    = 0;
        errors     = 0;
        seen_cnt   = 0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        stall_seen = 1'b0;
        seen       = 0;
        passed     = 0;
        failed     = 0;
    end

    // ====================
    // commit compare
    // ====================

    task check_commit();
        if (cur_test >= NUM_TESTS) begin
            $display("commit to x%0d arrived after the last test", commit.rd);
            fail_cnt++;
            return;
        end
        // skip rows that should never commit
        while (row_ptr < last_row && !ROWS[row_ptr].commits) begin
            row_ptr++;
        end
        if (row_ptr >= last_row) begin
            $display("%s: unexpected extra commit to x%0d with value 0x%08h",
                     TEST_NAME[cur_test], commit.rd, commit.value);
            errors++;
        end else begin
            if (commit.rd !== ROWS[row_ptr].rd || commit.value !== ROWS[row_ptr].value) begin
                $display("ERR %s: expected x%0d=0x%08h actual x%0d=0x%08h",
                         TEST_NAME[cur_test], ROWS[row_ptr].rd, ROWS[row_ptr].value,
                         commit.rd, commit.value);
                errors++;
            end
            row_ptr++;
        end
        seen_cnt++;
    endtask

    // per-test verdict, then move to the next slice of rows
    task close_test();
        int missing;
        missing = count_expected_commits(first_row, TEST_ROWS[cur_test]) - seen_cnt;
        if (missing > 0) begin
            $display("%s: %0d expected commits never appeared", TEST_NAME[cur_test], missing);
            errors++;
        end
        if (TEST_STALL[cur_test] == STALL_SEEN && !stall_seen) begin
            $display("%s: stall never went high", TEST_NAME[cur_test]);
            errors++;
        end
        if (TEST_STALL[cur_test] == STALL_NEVER && stall_seen) begin
            $display("%s: stall went high with nothing to dispatch", TEST_NAME[cur_test]);
            errors++;
        end
        if (errors == 0) begin
            $display("test %-18s ok, %0d commits", TEST_NAME[cur_test], seen_cnt);
            pass_cnt++;
        end else begin
            $display("test %-18s failed with %0d errors", TEST_NAME[cur_test], errors);
            fail_cnt++;
        end
        first_row += TEST_ROWS[cur_test];
        cur_test++;
        last_row   = (cur_test < NUM_TESTS) ? first_row + TEST_ROWS[cur_test] : first_row;
        row_ptr    = first_row;
        errors     = 0;
        seen_cnt   = 0;
        stall_seen = 1'b0;
    endtask

    // sample at the edge, outputs are all registered or stable by then
    always @(posedge clk) begin
        if (!reset) begin
            if (stall) begin
                stall_seen = 1'b1;
            end
            if (commit.valid) begin
                check_commit();
            end
            if (test_end && cur_test < NUM_TESTS) begin
                close_test();
            end
        end
        seen   <= seen_cnt;
        passed <= pass_cnt;
        failed <= fail_cnt;
    end

endmodule

//--- verilog/tomasulo_core.sv
`timescale 1ns/100ps

module tomasulo_core import core_pkg::*; #(
    parameter int RS_DEPTH = 4
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] instr,
    input  logic        instr_valid,
    output logic        stall,
    output commit_t     commit
);

    // ====================
    // stage wiring
    // ====================

    decoded_t            dec;
    logic                dispatch;
    logic [RS_DEPTH-1:0] rs_slot;
    logic [RS_DEPTH-1:0] rs_busy;
    logic                rob_full;
    logic [TAG_W-1:0]    alloc_tag;
    commit_t             retire;
    logic [TAG_W-1:0]    retire_tag;
    // rename to rob lookup
    logic [TAG_W-1:0]    rob_tag1;
    logic [TAG_W-1:0]    rob_tag2;
    logic                rob_ready1;
    logic                rob_ready2;
    logic [XLEN-1:0]     rob_value1;
    logic [XLEN-1:0]     rob_value2;
    operand_t            src1;
    operand_t            src2;
    issue_t              issue;
    cdb_t                cdb;

    instr_decode u_decode (
        .clk         (clk),
        .reset       (reset),
        .instr       (instr),
        .instr_valid (instr_valid),
        .stall       (stall),
        .dec         (dec)
    );

    dispatch_ctrl #(.RS_DEPTH(RS_DEPTH)) u_dispatch (
        .dec      (dec),
        .rob_full (rob_full),
        .rs_busy  (rs_busy),
        .stall    (stall),
        .dispatch (dispatch),
        .rs_slot  (rs_slot)
    );

    rename_table u_rename (
        .clk        (clk),
        .reset      (reset),
        .dec        (dec),
        .dispatch   (dispatch),
        .alloc_tag  (alloc_tag),
        .retire     (retire),
        .retire_tag (retire_tag),
        .cdb        (cdb),
        .rob_ready1 (rob_ready1),
        .rob_value1 (rob_value1),
        .rob_ready2 (rob_ready2),
        .rob_value2 (rob_value2),
        .rob_tag1   (rob_tag1),
        .rob_tag2   (rob_tag2),
        .src1       (src1),
        .src2       (src2)
    );

    rob u_rob (
        .clk        (clk),
        .reset      (reset),
        .dispatch   (dispatch),
        .dec        (dec),
        .cdb        (cdb),
        .rob_tag1   (rob_tag1),
        .rob_tag2   (rob_tag2),
        .alloc_tag  (alloc_tag),
        .rob_full   (rob_full),
        .rob_ready1 (rob_ready1),
        .rob_value1 (rob_value1),
        .rob_ready2 (rob_ready2),
        .rob_value2 (rob_value2),
        .retire     (retire),
        .retire_tag (retire_tag),
        .commit     (commit)
    );

    add_sub_rs #(.RS_DEPTH(RS_DEPTH)) u_rs (
        .clk       (clk),
        .reset     (reset),
        .dispatch  (dispatch),
        .rs_slot   (rs_slot),
        .dec       (dec),
        .alloc_tag (alloc_tag),
        .src1      (src1),
        .src2      (src2),
        .cdb       (cdb),
        .rs_busy   (rs_busy),
        .issue     (issue)
    );

    // bus fans out to station, rob and rename
    add_sub_unit u_alu (
        .clk   (clk),
        .reset (reset),
        .issue (issue),
        .cdb   (cdb)
    );

endmodule

//--- verilog/add_sub_unit.sv
`timescale 1ns/100ps

module add_sub_unit import core_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  issue_t issue,
    output cdb_t   cdb
);

    // single execute stage, result goes straight onto the bus
    always_ff @(posedge clk) begin
        if (reset) begin
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= issue.valid;
            cdb.tag   <= issue.tag;
            // wraps modulo 2^32
            case (issue.op)
                SUB:     cdb.value <= issue.value1 - issue.value2;
                default: cdb.value <= issue.value1 + issue.value2;
            endcase
        end
    end

endmodule

//--- verilog/add_sub_rs.sv
`timescale 1ns/100ps

module add_sub_rs import core_pkg::*; #(
    parameter int RS_DEPTH = 4
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                dispatch,
    input  logic [RS_DEPTH-1:0] rs_slot,
    input  decoded_t            dec,
    input  logic [TAG_W-1:0]    alloc_tag,
    input  operand_t            src1,
    input  operand_t            src2,
    input  cdb_t                cdb,
    output logic [RS_DEPTH-1:0] rs_busy,
    output issue_t              issue
);

    localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;

    typedef struct packed {
        alu_op_e          op;
        logic [TAG_W-1:0] tag;
        operand_t         src1;
        operand_t         src2;
    } rs_entry_t;

    rs_entry_t           entry [RS_DEPTH];
    logic [RS_DEPTH-1:0] busy;
    logic                sel_valid;
    logic [IDX_W-1:0]    sel_idx;

    // pick up a waiting operand when its producer broadcasts
    function automatic operand_t snoop(input operand_t opnd, input cdb_t bus);
        operand_t res;
        res = opnd;
        if (!opnd.ready && bus.valid && bus.tag == opnd.tag) begin
            res.ready = 1'b1;
            res.value = bus.value;
        end
        return res;
    endfunction

    assign rs_busy = busy;

    // ====================
    // select
    // ====================

    // walk down so the lowest ready entry wins
    always_comb begin
        sel_valid = 1'b0;
        sel_idx   = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (busy[i] && entry[i].src1.ready && entry[i].src2.ready) begin
                sel_valid = 1'b1;
                sel_idx   = IDX_W'(i);
            end
        end
    end

    // busy set on dispatch, cleared when issued
    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= '0;
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (dispatch && rs_slot[i]) begin
                    busy[i] <= 1'b1;
                end else if (sel_valid && sel_idx == IDX_W'(i)) begin
                    busy[i] <= 1'b0;
                end
            end
        end
    end

    // entry write or bus capture
    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (dispatch && rs_slot[i]) begin
                entry[i] <= '{op: dec.op, tag: alloc_tag, src1: src1, src2: src2};
            end else begin
                entry[i].src1 <= snoop(entry[i].src1, cdb);
                entry[i].src2 <= snoop(entry[i].src2, cdb);
            end
        end
    end

    // ====================
    // issue register
    // ====================

    always_ff @(posedge clk) begin
        if (reset) begin
            issue.valid <= 1'b0;
        end else begin
            issue.valid  <= sel_valid;
            issue.op     <= entry[sel_idx].op;
            issue.tag    <= entry[sel_idx].tag;
            issue.value1 <= entry[sel_idx].src1.value;
            issue.value2 <= entry[sel_idx].src2.value;
        end
    end

    // slot pick from dispatch control must be free here
    slot_free_on_write: assert property (@(posedge clk) disable iff (reset)
        dispatch |-> (rs_slot & busy) == '0);

endmodule

//--- verilog/rob.sv
`timescale 1ns/100ps

module rob import core_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  logic             dispatch,
    input  decoded_t         dec,
    input  cdb_t             cdb,
    input  logic [TAG_W-1:0] rob_tag1,
    input  logic [TAG_W-1:0] rob_tag2,
    output logic [TAG_W-1:0] alloc_tag,
    output logic             rob_full,
    output logic             rob_ready1,
    output logic [XLEN-1:0]  rob_value1,
    output logic             rob_ready2,
    output logic [XLEN-1:0]  rob_value2,
    output commit_t          retire,
    output logic [TAG_W-1:0] retire_tag,
    output commit_t          commit
);

    logic [TAG_W-1:0]     head;
    logic [TAG_W-1:0]     tail;
    logic [ROB_DEPTH-1:0] busy;
    logic [ROB_DEPTH-1:0] ready;
    logic [REG_W-1:0]     rd_q    [ROB_DEPTH];
    logic [XLEN-1:0]      value_q [ROB_DEPTH];

    // ====================
    // ports out
    // ====================

    // tail always points at the next entry to hand out
    assign alloc_tag = tail;
    // entries free in order, so a busy tail means full
    assign rob_full  = busy[tail];

    // lookup ports for rename
    assign rob_ready1 = ready[rob_tag1];
    assign rob_value1 = value_q[rob_tag1];
    assign rob_ready2 = ready[rob_tag2];
    assign rob_value2 = value_q[rob_tag2];

    // head leaves as soon as its result is back
    assign retire = '{valid: busy[head] && ready[head], rd: rd_q[head], value: value_q[head]};
    assign retire_tag = head;

    // ====================
    // pointers and flags
    // ====================

    always_ff @(posedge clk) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            busy  <= '0;
            ready <= '0;
        end else begin
            if (dispatch) begin
                busy[tail]  <= 1'b1;
                ready[tail] <= 1'b0;
                tail        <= tail + 1'b1;
            end
            // writeback from the bus
            if (cdb.valid) begin
                ready[cdb.tag] <= 1'b1;
            end
            if (retire.valid) begin
                busy[head]  <= 1'b0;
                ready[head] <= 1'b0;
                head        <= head + 1'b1;
            end
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (dispatch) begin
            rd_q[tail] <= dec.rd;
        end
        if (cdb.valid) begin
            value_q[cdb.tag] <= cdb.value;
        end
    end

    // commit port, one cycle behind retire
    always_ff @(posedge clk) begin
        if (reset) begin
            commit.valid <= 1'b0;
        end else begin
            commit <= retire;
        end
    end

    // dispatch control has to hold words while every entry is in flight
    no_alloc_when_full: assert property (@(posedge clk) disable iff (reset)
        dispatch |-> !rob_full);

    // results only land on entries still waiting for them
    cdb_hits_busy: assert property (@(posedge clk) disable iff (reset)
        cdb.valid |-> busy[cdb.tag] && !ready[cdb.tag]);

endmodule

//--- verilog/rename_table.sv
`timescale 1ns/100ps

module rename_table import core_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  decoded_t         dec,
    input  logic             dispatch,
    input  logic [TAG_W-1:0] alloc_tag,
    input  commit_t          retire,
    input  logic [TAG_W-1:0] retire_tag,
    input  cdb_t             cdb,
    input  logic             rob_ready1,
    input  logic [XLEN-1:0]  rob_value1,
    input  logic             rob_ready2,
    input  logic [XLEN-1:0]  rob_value2,
    output logic [TAG_W-1:0] rob_tag1,
    output logic [TAG_W-1:0] rob_tag2,
    output operand_t         src1,
    output operand_t         src2
);

    logic [XLEN-1:0]     regs    [NUM_REGS];
    logic [NUM_REGS-1:0] mapped;
    logic [TAG_W-1:0]    rat_tag [NUM_REGS];

    // register file, then rob entry, then bus, else wait
    function automatic operand_t resolve(
        input logic             is_mapped,
        input logic [TAG_W-1:0] tag,
        input logic [XLEN-1:0]  reg_value,
        input logic             rob_ready,
        input logic [XLEN-1:0]  rob_value,
        input cdb_t             bus
    );
        operand_t res;
        res.tag   = tag;
        res.ready = 1'b1;
        if (!is_mapped) begin
            res.value = reg_value;
        end else if (rob_ready) begin
            res.value = rob_value;
        end else if (bus.valid && bus.tag == tag) begin
            // producer broadcasting right now
            res.value = bus.value;
        end else begin
            res.ready = 1'b0;
            res.value = '0;
        end
        return res;
    endfunction

    // ====================
    // operand lookup
    // ====================

    assign rob_tag1 = rat_tag[dec.rs1];
    assign rob_tag2 = rat_tag[dec.rs2];

    // x0 never renamed
    assign src1 = resolve(mapped[dec.rs1] && dec.rs1 != '0, rob_tag1,
                          regs[dec.rs1], rob_ready1, rob_value1, cdb);
    assign src2 = resolve(mapped[dec.rs2] && dec.rs2 != '0, rob_tag2,
                          regs[dec.rs2], rob_ready2, rob_value2, cdb);

    // ====================
    // retire and rename
    // ====================

    always_ff @(posedge clk) begin
        if (reset) begin
            regs    <= REG_RESET_VALUES;
            mapped  <= '0;
            rat_tag <= '{default: '0};
        end else begin
            if (retire.valid) begin
                if (retire.rd != '0) begin
                    regs[retire.rd] <= retire.value;
                end
                // younger writer keeps its mapping
                if (rat_tag[retire.rd] == retire_tag) begin
                    mapped[retire.rd] <= 1'b0;
                end
            end
            // later assignment, so dispatch wins on the same rd
            if (dispatch && dec.rd != '0) begin
                mapped[dec.rd]  <= 1'b1;
                rat_tag[dec.rd] <= alloc_tag;
            end
        end
    end

endmodule

//--- verilog/dispatch_ctrl.sv
`timescale 1ns/100ps

module dispatch_ctrl import core_pkg::*; #(
    parameter int RS_DEPTH = 4
) (
    input  decoded_t            dec,
    input  logic                rob_full,
    input  logic [RS_DEPTH-1:0] rs_busy,
    output logic                stall,
    output logic                dispatch,
    output logic [RS_DEPTH-1:0] rs_slot
);

    logic is_alu;
    logic slot_free;

    // ====================
    // flow decision
    // ====================

    // only add/sub need resources
    assign is_alu = (dec.op == ADD) || (dec.op == SUB);

    // lowest clear bit of busy
    // all ones wraps to zero, so no slot
    assign rs_slot = ~rs_busy & (rs_busy + 1'b1);
    assign slot_free = |rs_slot;

    // hold decode when rob or station can't take the word
    assign stall = is_alu && (rob_full || !slot_free);

    // bubbles and dropped ops just fall through
    assign dispatch = is_alu && !stall;

    // station writes exactly one entry per dispatch
    dispatch_one_hot: assert final (!dispatch || $onehot(rs_slot));

endmodule

//--- verilog/instr_decode.sv
`timescale 1ns/100ps

module instr_decode import core_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] instr,
    input  logic        instr_valid,
    input  logic        stall,
    output decoded_t    dec
);

    // empty slot in the decode register
    localparam decoded_t BUBBLE = '{op: NONE, default: '0};

    // classify one word, anything but add/sub turns into a bubble
    function automatic decoded_t classify(input logic [31:0] word);
        decoded_t d;
        d.op  = NONE;
        d.rd  = word[11:7];
        d.rs1 = word[19:15];
        d.rs2 = word[24:20];
        if (word[6:0] == OPC_OP) begin
            case (word[31:25])
                // only funct3 000 is add or sub
                F7_ADD:    d.op = (word[14:12] == 3'b000) ? ADD : NONE;
                F7_SUB:    d.op = (word[14:12] == 3'b000) ? SUB : NONE;
                // mul and div have no unit here
                F7_MULDIV: d.op = NONE;
                default:   d.op = NONE;
            endcase
        end else if (word[6:0] == OPC_LOAD) begin
            // loads dropped with the memory path
            d.op = NONE;
        end
        return d;
    endfunction

    // hold while stalled, word only lands when accepted
    always_ff @(posedge clk) begin
        if (reset) begin
            dec <= BUBBLE;
        end else if (!stall) begin
            dec <= instr_valid ? classify(instr) : BUBBLE;
        end
    end

endmodule

//--- verilog/core_pkg.sv
package core_pkg;

    // ====================
    // widths and depths
    // ====================

    localparam int XLEN      = 32;
    localparam int NUM_REGS  = 32;
    localparam int REG_W     = 5;
    // tag indexes the reorder buffer directly
    localparam int ROB_DEPTH = 8;
    localparam int TAG_W     = 3;

    // rv32 opcode and funct7 fields
    localparam logic [6:0] OPC_OP    = 7'b0110011;
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] F7_ADD    = 7'b0000000;
    localparam logic [6:0] F7_SUB    = 7'b0100000;
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    // register file contents out of reset, x0 stays zero
    localparam logic [XLEN-1:0] REG_RESET_VALUES [NUM_REGS] = '{
        1:       32'h0000_000c,
        2:       32'h0000_0010,
        3:       32'h0000_002d,
        4:       32'h0000_0005,
        5:       32'h0000_0003,
        6:       32'h0000_0004,
        7:       32'h0000_0001,
        8:       32'h0000_0002,
        9:       32'h0000_0002,
        10:      32'h0000_0003,
        default: '0
    };

    // ====================
    // shared types
    // ====================

    typedef enum logic [1:0] {
        NONE = 2'd0,
        ADD  = 2'd1,
        SUB  = 2'd2
    } alu_op_e;

    typedef struct packed {
        alu_op_e          op;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rs1;
        logic [REG_W-1:0] rs2;
    } decoded_t;

    // ready means value is valid, else waiting on tag
    typedef struct packed {
        logic             ready;
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  value;
    } operand_t;

    typedef struct packed {
        logic             valid;
        alu_op_e          op;
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  value1;
        logic [XLEN-1:0]  value2;
    } issue_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  value;
    } cdb_t;

    typedef struct packed {
        logic             valid;
        logic [REG_W-1:0] rd;
        logic [XLEN-1:0]  value;
    } commit_t;

endpackage
